//--- Bender.yml
package:
  name: tlb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tlbPkg.sv
      - rtl/tlbRequestSplit.sv
      - rtl/tlbEntrySlot.sv
      - rtl/tlbHitResolve.sv
      - rtl/tlbTop.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tlbTb.sv

//--- flist.f
+incdir+rtl
rtl/tlbPkg.sv
rtl/tlbRequestSplit.sv
rtl/tlbEntrySlot.sv
rtl/tlbHitResolve.sv
rtl/tlbTop.sv
sim/tlbTb.sv

//--- rtl/tlbEntrySlot.sv
`include "tlb_cfg.svh"

module tlbEntrySlot
	import tlbPkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic write_i,
	input tlbEntry_t writeEntry_i,
	input tlbKey_t dataKey_i,
	input tlbKey_t probeKey_i,

	output tlbEntry_t entry_o,
	output logic dataMatch_o,
	output logic probeMatch_o
);

	tlbEntry_t entryQ;

	// vpn2 must agree, asid only matters for non-global entries
	function automatic logic keyMatch(input tlbEntry_t entry, input tlbKey_t key);
		logic vpnEq;
		logic asidEq;
		vpnEq = (entry.vpn2 == key.vpn2);
		asidEq = (entry.asid == key.asid);
		return vpnEq && (asidEq || entry.global);
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			entryQ <= '0;
		end
		else if (write_i)
		begin
			entryQ <= writeEntry_i;
		end
	end

	assign entry_o = entryQ;

	// both comparators work on the stored value
	always_comb
	begin
		dataMatch_o = keyMatch(entryQ, dataKey_i);
		probeMatch_o = keyMatch(entryQ, probeKey_i);
	end

endmodule

//--- rtl/tlbHitResolve.sv
`include "tlb_cfg.svh"

module tlbHitResolve
	import tlbPkg::*;
(
	input tlbEntry_t entries_i [`TLB_ENTRIES],
	input logic [`TLB_ENTRIES-1:0] dataMatch_i,
	input logic [`TLB_ENTRIES-1:0] probeMatch_i,
	input logic oddPage_i,
	input logic [`TLB_OFFSET_W-1:0] pageOffset_i,
	input logic [`TLB_IDX_W-1:0] entryIndex_i,

	output tlbTrans_t dataTrans_o,
	output tlbProbe_t probeResult_o,
	output tlbEntry_t readEntry_o
);

	logic [`TLB_IDX_W-1:0] dataIdx;
	logic [`TLB_IDX_W-1:0] probeIdx;
	logic dataHit;
	logic probeHit;
	tlbEntry_t dataEntry;
	tlbPage_t dataPage;

	// lowest set bit wins, index 0 when nothing matches
	function automatic logic [`TLB_IDX_W-1:0] lowestIndex(
		input logic [`TLB_ENTRIES-1:0] match
	);
		logic [`TLB_IDX_W-1:0] idx;
		idx = '0;
		for (int i = `TLB_ENTRIES-1; i >= 0; i--)
		begin
			if (match[i])
			begin
				idx = `TLB_IDX_W'(i);
			end
		end
		return idx;
	endfunction

	always_comb
	begin
		dataIdx = lowestIndex(dataMatch_i);
		probeIdx = lowestIndex(probeMatch_i);
		dataHit = |dataMatch_i;
		probeHit = |probeMatch_i;
	end

	// pick the page of the pair
	always_comb
	begin
		dataEntry = entries_i[dataIdx];
		if (oddPage_i)
		begin
			dataPage = dataEntry.odd;
		end
		else
		begin
			dataPage = dataEntry.even;
		end
	end

	// on a miss the fields still come from entry 0
	always_comb
	begin
		dataTrans_o.paddr = {dataPage.pfn, pageOffset_i};
		dataTrans_o.miss = ~dataHit;
		dataTrans_o.dirty = dataPage.dirty;
		dataTrans_o.valid = dataPage.valid;
		dataTrans_o.uncached = (dataPage.cache == `TLB_CACHE_UNCACHED);
	end

	// Index register format: P bit on top, index at the bottom
	always_comb
	begin
		probeResult_o.miss = ~probeHit;
		probeResult_o.zero = '0;
		probeResult_o.index = probeIdx;
	end

	// tlbr
	assign readEntry_o = entries_i[entryIndex_i];

endmodule

//--- rtl/tlbPkg.sv
`include "tlb_cfg.svh"

package tlbPkg;

	// one half of an entry, EntryLo0 or EntryLo1
	typedef struct packed {
		logic [`TLB_PFN_W-1:0] pfn;
		logic [`TLB_CACHE_W-1:0] cache;
		logic dirty;
		logic valid;
	} tlbPage_t;

	// full entry as written by tlbwi and returned by tlbr
	typedef struct packed {
		logic [`TLB_VPN2_W-1:0] vpn2;
		logic [`TLB_ASID_W-1:0] asid;
		logic global;
		tlbPage_t even;
		tlbPage_t odd;
	} tlbEntry_t;

	// what a lookup compares against
	typedef struct packed {
		logic [`TLB_VPN2_W-1:0] vpn2;
		logic [`TLB_ASID_W-1:0] asid;
	} tlbKey_t;

	// data side translation
	typedef struct packed {
		logic [`TLB_PADDR_W-1:0] paddr;
		logic miss;
		logic dirty;
		logic valid;
		logic uncached;
	} tlbTrans_t;

	// laid out like the CP0 Index register
	typedef struct packed {
		logic miss;
		logic [`TLB_VADDR_W-`TLB_IDX_W-2:0] zero;
		logic [`TLB_IDX_W-1:0] index;
	} tlbProbe_t;

endpackage

//--- rtl/tlbRequestSplit.sv
`include "tlb_cfg.svh"

module tlbRequestSplit
	import tlbPkg::*;
(
	input logic writeEn_i,
	input logic [`TLB_IDX_W-1:0] entryIndex_i,
	input tlbEntry_t writeEntry_i,
	input logic [`TLB_VADDR_W-1:0] dataVaddr_i,
	input logic [`TLB_ASID_W-1:0] asid_i,

	output tlbKey_t dataKey_o,
	output tlbKey_t probeKey_o,
	output logic [`TLB_ENTRIES-1:0] slotWrite_o,
	output logic oddPage_o,
	output logic [`TLB_OFFSET_W-1:0] pageOffset_o
);

	// data lookup uses the upper address bits
	always_comb
	begin
		dataKey_o.vpn2 = dataVaddr_i[`TLB_VADDR_W-1 -: `TLB_VPN2_W];
		dataKey_o.asid = asid_i;
	end

	// tlbp searches for the EntryHi being written
	always_comb
	begin
		probeKey_o.vpn2 = writeEntry_i.vpn2;
		probeKey_o.asid = asid_i;
	end

	// one-hot write enable, at most one slot per cycle
	always_comb
	begin
		slotWrite_o = '0;
		if (writeEn_i)
		begin
			slotWrite_o[entryIndex_i] = 1'b1;
		end
	end

	assign oddPage_o = dataVaddr_i[`TLB_ODD_BIT];
	assign pageOffset_o = dataVaddr_i[`TLB_OFFSET_W-1:0];

endmodule

//--- rtl/tlbTop.sv
`include "tlb_cfg.svh"

module tlbTop
	import tlbPkg::*;
(
	input logic clk,
	input logic rst_n,

	// tlbwi / tlbr
	input logic writeEn_i,
	input logic [`TLB_IDX_W-1:0] entryIndex_i,
	input tlbEntry_t writeEntry_i,

	// data side lookup
	input logic [`TLB_VADDR_W-1:0] dataVaddr_i,
	input logic [`TLB_ASID_W-1:0] asid_i,

	output tlbEntry_t readEntry_o,
	output tlbTrans_t dataTrans_o,
	output tlbProbe_t probeResult_o
);

	tlbKey_t dataKey;
	tlbKey_t probeKey;
	logic [`TLB_ENTRIES-1:0] slotWrite;
	logic oddPage;
	logic [`TLB_OFFSET_W-1:0] pageOffset;

	tlbEntry_t entries [`TLB_ENTRIES];
	logic [`TLB_ENTRIES-1:0] dataMatch;
	logic [`TLB_ENTRIES-1:0] probeMatch;

	tlbRequestSplit requestSplit_i (
		.writeEn_i(writeEn_i),
		.entryIndex_i(entryIndex_i),
		.writeEntry_i(writeEntry_i),
		.dataVaddr_i(dataVaddr_i),
		.asid_i(asid_i),
		.dataKey_o(dataKey),
		.probeKey_o(probeKey),
		.slotWrite_o(slotWrite),
		.oddPage_o(oddPage),
		.pageOffset_o(pageOffset)
	);

	for (genvar g = 0; g < `TLB_ENTRIES; g++)
	begin : gSlot
		tlbEntrySlot entrySlot_i (
			.clk(clk),
			.rst_n(rst_n),
			.write_i(slotWrite[g]),
			.writeEntry_i(writeEntry_i),
			.dataKey_i(dataKey),
			.probeKey_i(probeKey),
			.entry_o(entries[g]),
			.dataMatch_o(dataMatch[g]),
			.probeMatch_o(probeMatch[g])
		);
	end

	tlbHitResolve hitResolve_i (
		.entries_i(entries),
		.dataMatch_i(dataMatch),
		.probeMatch_i(probeMatch),
		.oddPage_i(oddPage),
		.pageOffset_i(pageOffset),
		.entryIndex_i(entryIndex_i),
		.dataTrans_o(dataTrans_o),
		.probeResult_o(probeResult_o),
		.readEntry_o(readEntry_o)
	);

endmodule

//--- rtl/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// entry array geometry
`define TLB_ENTRIES 32
`define TLB_IDX_W 5

// address widths
`define TLB_VADDR_W 32
`define TLB_PADDR_W 32

// virtual page pair number, vaddr[31:13]
`define TLB_VPN2_W 19

// physical frame number of one 4K page
`define TLB_PFN_W 20

`define TLB_ASID_W 8

// offset inside a 4K page
`define TLB_OFFSET_W 12

// vaddr[12] selects even or odd page of the pair
`define TLB_ODD_BIT 12

// EntryLo C field
`define TLB_CACHE_W 3
`define TLB_CACHE_UNCACHED 3'd2

`endif

//--- sim/tlbTb.sv
`include "tlb_cfg.svh"

module tlbTb
	import tlbPkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;

	// upper bound of cycles for each test
	localparam int READ_CYCLES = 3 * `TLB_ENTRIES + 2;
	localparam int PAGE_CYCLES = 64 + 2;
	localparam int ASID_CYCLES = 8 + 16 + 2;
	localparam int PROBE_CYCLES = 4 + 12 + 2;
	localparam int UNCACHED_CYCLES = 8 + 16 + 2;
	localparam int RESET_TEST_CYCLES = RESET_CYCLES + `TLB_ENTRIES + 12;
	localparam int TEST_CYCLES = RESET_CYCLES + READ_CYCLES + PAGE_CYCLES + ASID_CYCLES
		+ PROBE_CYCLES + UNCACHED_CYCLES + RESET_TEST_CYCLES;
	localparam int TIMEOUT_TIME = TEST_CYCLES * CLK_PERIOD * 2;

	logic clk;
	logic rst_n;
	logic writeEn;
	logic [`TLB_IDX_W-1:0] entryIndex;
	tlbEntry_t writeEntry;
	logic [`TLB_VADDR_W-1:0] dataVaddr;
	logic [`TLB_ASID_W-1:0] asid;

	tlbEntry_t readEntry;
	tlbTrans_t dataTrans;
	tlbProbe_t probeResult;

	// reference model state and expected outputs
	tlbEntry_t model [`TLB_ENTRIES];
	tlbEntry_t expRead;
	tlbTrans_t expTrans;
	tlbProbe_t expProbe;
	tlbPage_t expPage;
	logic dataFound;
	int dataIdx;
	logic probeFound;
	int probeIdx;

	logic checkEn;
	int seed = 32'h235c;
	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testErrStart = 0;

	tlbTop tlbTop_i (
		.clk(clk),
		.rst_n(rst_n),
		.writeEn_i(writeEn),
		.entryIndex_i(entryIndex),
		.writeEntry_i(writeEntry),
		.dataVaddr_i(dataVaddr),
		.asid_i(asid),
		.readEntry_o(readEntry),
		.dataTrans_o(dataTrans),
		.probeResult_o(probeResult)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// vpn2 equal and asid equal unless global
	function automatic logic entryHits(input tlbEntry_t e, input logic [`TLB_VPN2_W-1:0] vpn2,
		input logic [`TLB_ASID_W-1:0] id);
		return (e.vpn2 == vpn2) && (e.global || (e.asid == id));
	endfunction

	function automatic tlbEntry_t randomEntry();
		logic [95:0] bits;
		bits = {$random(seed), $random(seed), $random(seed)};
		return tlbEntry_t'(bits[77:0]);
	endfunction

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				model[i] <= '0;
			end
		end
		else if (writeEn)
		begin
			model[entryIndex] <= writeEntry;
		end
	end

	always_comb
	begin
		dataFound = 1'b0;
		dataIdx = 0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			if (!dataFound && entryHits(model[i], dataVaddr[31:13], asid))
			begin
				dataFound = 1'b1;
				dataIdx = i;
			end
		end
		// a miss still shows entry 0
		if (dataVaddr[`TLB_ODD_BIT])
		begin
			expPage = model[dataIdx].odd;
		end
		else
		begin
			expPage = model[dataIdx].even;
		end
		expTrans.paddr = {expPage.pfn, dataVaddr[11:0]};
		expTrans.miss = !dataFound;
		expTrans.dirty = expPage.dirty;
		expTrans.valid = expPage.valid;
		expTrans.uncached = (expPage.cache == `TLB_CACHE_UNCACHED);
	end

	always_comb
	begin
		probeFound = 1'b0;
		probeIdx = 0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			if (!probeFound && entryHits(model[i], writeEntry.vpn2, asid))
			begin
				probeFound = 1'b1;
				probeIdx = i;
			end
		end
		expProbe.miss = !probeFound;
		expProbe.zero = '0;
		expProbe.index = probeIdx[`TLB_IDX_W-1:0];
	end

	assign expRead = model[entryIndex];

	task automatic reportMismatch(input string name, input logic [127:0] expVal,
		input logic [127:0] actVal);
		$display("Mismatch %s: expected %h, got %h at %0t", name, expVal, actVal, $time);
		errorCount++;
	endtask

	readCheck: assert property (@(negedge clk) disable iff (!checkEn) readEntry == expRead)
		else reportMismatch("readEntry_o", expRead, readEntry);
	transCheck: assert property (@(negedge clk) disable iff (!checkEn) dataTrans == expTrans)
		else reportMismatch("dataTrans_o", expTrans, dataTrans);
	probeCheck: assert property (@(negedge clk) disable iff (!checkEn) probeResult == expProbe)
		else reportMismatch("probeResult_o", expProbe, probeResult);

	always @(negedge clk)
	begin
		if (checkEn)
		begin
			checkCount <= checkCount + 3;
		end
	end

	task automatic afterEdge();
		@(posedge clk);
		#2;
	endtask

	task automatic writeSlot(input int idx, input tlbEntry_t e);
		afterEdge();
		writeEn = 1'b1;
		entryIndex = idx[`TLB_IDX_W-1:0];
		writeEntry = e;
	endtask

	task automatic holdIdle();
		afterEdge();
		writeEn = 1'b0;
	endtask

	task automatic readSlot(input int idx);
		afterEdge();
		writeEn = 1'b0;
		entryIndex = idx[`TLB_IDX_W-1:0];
	endtask

	task automatic lookupAddr(input logic [`TLB_VADDR_W-1:0] va, input logic [`TLB_ASID_W-1:0] id);
		afterEdge();
		writeEn = 1'b0;
		dataVaddr = va;
		asid = id;
	endtask

	// probe key is the vpn2 on the write entry port
	task automatic probeVpn(input logic [`TLB_VPN2_W-1:0] vpn2, input logic [`TLB_ASID_W-1:0] id);
		afterEdge();
		writeEn = 1'b0;
		writeEntry.vpn2 = vpn2;
		asid = id;
	endtask

	task automatic finishTest(input string name);
		@(negedge clk);
		#1;
		$display("test %s finished with %0d errors", name, errorCount - testErrStart);
		testErrStart = errorCount;
		testsRun++;
	endtask

	initial
	begin
		#(TIMEOUT_TIME);
		$display("watchdog: run did not finish within %0d time units", TIMEOUT_TIME);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		tlbEntry_t e;
		int k;
		logic oddBit;
		logic [11:0] offset;
		logic [31:0] rnd;

		rst_n = 1'b0;
		writeEn = 1'b0;
		entryIndex = '0;
		writeEntry = '0;
		dataVaddr = '0;
		asid = '0;
		checkEn = 1'b0;

		repeat (RESET_CYCLES) afterEdge();
		rst_n = 1'b1;
		checkEn = 1'b1;

		// every write read back on the following cycle
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			writeSlot(i, randomEntry());
			holdIdle();
		end
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			readSlot(i);
		end
		finishTest("read after write");

		// addresses from stored pairs with random page half and offset
		for (int n = 0; n < 64; n++)
		begin
			rnd = $random(seed);
			k = rnd % `TLB_ENTRIES;
			oddBit = rnd[`TLB_ODD_BIT];
			offset = rnd[31:20];
			lookupAddr({model[k].vpn2, oddBit, offset}, model[k].asid);
		end
		finishTest("even and odd translation");

		// odd indices global and lookups under own and foreign asid
		for (int i = 0; i < 8; i++)
		begin
			e = randomEntry();
			e.vpn2 = 19'h4a000 + i[18:0];
			e.asid = 8'h30 + i[7:0];
			e.global = i[0];
			writeSlot(i, e);
		end
		holdIdle();
		for (int i = 0; i < 8; i++)
		begin
			lookupAddr({19'h4a000 + i[18:0], 13'h0a5}, 8'h30 + i[7:0]);
			lookupAddr({19'h4a000 + i[18:0], 13'h1f3c}, 8'hc5);
		end
		finishTest("asid and global");

		// duplicates at 20 and 25 where the lower one wins
		e = randomEntry();
		e.vpn2 = 19'h12345;
		e.asid = 8'h44;
		e.global = 1'b0;
		writeSlot(25, e);
		writeSlot(20, e);
		e.asid = 8'h55;
		writeSlot(22, e);
		holdIdle();
		probeVpn(19'h12345, 8'h44);
		probeVpn(19'h12345, 8'h55);
		probeVpn(19'h12345, 8'h66);
		probeVpn(19'h7f0f0, 8'h99);
		lookupAddr({19'h12345, 13'h1000}, 8'h44);
		for (int i = 0; i < 8; i++)
		begin
			probeVpn(19'h4a000 + i[18:0], 8'h30 + i[7:0]);
		end
		finishTest("probe");

		// every cache code on both halves
		for (int i = 0; i < 8; i++)
		begin
			e = randomEntry();
			e.vpn2 = 19'h55000 + i[18:0];
			e.asid = 8'h21;
			e.global = 1'b1;
			e.even.cache = i[2:0];
			e.odd.cache = 3'd7 - i[2:0];
			writeSlot(8 + i, e);
		end
		holdIdle();
		for (int i = 0; i < 8; i++)
		begin
			lookupAddr({19'h55000 + i[18:0], 1'b0, 12'h3c0}, 8'h77);
			lookupAddr({19'h55000 + i[18:0], 1'b1, 12'h0fc}, 8'h77);
		end
		finishTest("uncached flag");

		// reset clears the whole array
		afterEdge();
		rst_n = 1'b0;
		repeat (RESET_CYCLES) afterEdge();
		rst_n = 1'b1;
		dataVaddr = '0;
		asid = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			readSlot(i);
		end
		probeVpn('0, '0);
		for (int n = 0; n < 8; n++)
		begin
			rnd = $random(seed);
			lookupAddr(rnd | 32'h0000_2000, rnd[31:24]);
		end
		finishTest("after reset");

		$display("%0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
